/* tb.f */
verilog/ex_pkg.sv
verilog/alu.sv
verilog/mem_access_unit.sv
verilog/llbit_unit.sv
verilog/ex_result_latch.sv
verilog/ex_stage.sv
verification/ex_stage_assertions.sv
verification/tb_ex_stage.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module tb_ex_stage -o sim_tb_ex_stage

if ! ./obj_dir/sim_tb_ex_stage > sim.log 2>&1; then
    cat sim.log
    echo "Simulation exited with an error"
    exit 1
fi
cat sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
    exit 1
fi
grep -q "TEST RESULT: PASS" sim.log

/* verification/tb_ex_stage.sv */
`timescale 1ns/1ps

module tb_ex_stage
    import ex_pkg::*;
();

    localparam int MAX_CYCLES = 2000;              // Tests need a few hundred cycles
    localparam logic [31:0] TEST_PC = 32'h1c00_0100;

    logic         clk = 1'b0;
    logic         rst;
    dispatch_ex_t dispatch_ex;
    logic         llbit;
    csr_fwd_t     mem_fwd;
    csr_fwd_t     wb_fwd;
    logic         dcache_addr_ok;
    dcache_req_t  dcache_req;
    logic         pause;
    ex_mem_t      ex_mem;

    integer seed = 27952;
    int     cycle_count = 0;
    int     check_count = 0;
    int     error_count = 0;

    ex_stage DUT (
        .clk            (clk),
        .rst            (rst),
        .dispatch_ex    (dispatch_ex),
        .llbit          (llbit),
        .mem_fwd        (mem_fwd),
        .wb_fwd         (wb_fwd),
        .dcache_addr_ok (dcache_addr_ok),
        .dcache_req     (dcache_req),
        .pause          (pause),
        .ex_mem         (ex_mem)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: the run went past %0d cycles", MAX_CYCLES);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Compare tasks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("CHECK FAILED at %0t: %s expected %b, got %b", $time, name, exp, act);
        end
    endtask

    task automatic check_req(input string name, input dcache_req_t exp, input dcache_req_t act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference models
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic dispatch_ex_t make_op(aluop_e op, logic [31:0] a, logic [31:0] b,
                                             logic [13:0] imm);
        dispatch_ex_t d;
        d = '0;
        d.pc = TEST_PC;
        if (op == ALU_SCW) begin
            d.inst.fmt_2ri14.si14 = imm;
        end else begin
            d.inst.fmt_2ri12.si12 = imm[11:0];
        end
        d.inst_valid     = 1'b1;
        d.aluop          = op;
        d.reg1           = a;
        d.reg2           = b;
        d.reg_write_en   = !(op inside {ALU_STB, ALU_STH, ALU_STW});
        d.reg_write_addr = 5'd7;
        return d;
    endfunction

    function automatic logic [31:0] alu_model(aluop_e op, logic [31:0] a, logic [31:0] b);
        logic [63:0] s_prod;
        logic [63:0] u_prod;
        s_prod = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
        u_prod = {32'b0, a} * {32'b0, b};
        case (op)
            ALU_OR:     return a | b;
            ALU_NOR:    return ~(a | b);
            ALU_AND:    return a & b;
            ALU_XOR:    return a ^ b;
            ALU_SLLW:   return a << b[4:0];
            ALU_SRLW:   return a >> b[4:0];
            ALU_SRAW:   return $signed(a) >>> b[4:0];
            ALU_ADDW:   return a + b;
            ALU_SUBW:   return a - b;
            ALU_SLT:    return {31'b0, $signed(a) < $signed(b)};
            ALU_SLTU:   return {31'b0, a < b};
            ALU_MULW:   return s_prod[31:0];
            ALU_MULHW:  return s_prod[63:32];
            ALU_MULHWU: return u_prod[63:32];
            default:    return 32'b0;
        endcase
    endfunction

    function automatic dcache_req_t store_model(aluop_e op, logic [31:0] addr, logic [31:0] data);
        dcache_req_t r;
        r.valid = 1'b1;
        r.op    = 1'b1;
        r.addr  = addr;
        r.wdata = data;                                 // Full word for STW and SCW
        r.wstrb = 4'b1111;
        if (op == ALU_STB) begin
            r.wdata = {4{data[7:0]}};
            r.wstrb = 4'b0001 << addr[1:0];
        end else if (op == ALU_STH) begin
            r.wdata = {2{data[15:0]}};
            r.wstrb = addr[1] ? 4'b1100 : 4'b0011;
        end
        return r;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Drive helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic present(input dispatch_ex_t d);
        @(posedge clk);
        #1;
        dispatch_ex = d;
        #10;                                            // Let the combinational paths settle
    endtask

    task automatic capture();
        @(posedge clk);
        #1;
        dispatch_ex = '0;
    endtask

    task automatic align_case(input aluop_e op, input logic [1:0] low);
        logic [31:0] rnd;
        logic [31:0] base;
        logic        ale;
        rnd  = $random(seed);
        base = {rnd[31:2], 2'b00};
        ale  = (op inside {ALU_LDH, ALU_STH}) ? low[0] : |low;
        if (op inside {ALU_STH, ALU_STW}) begin
            present(make_op(op, base, rnd, {12'b0, low}));
        end else begin
            present(make_op(op, base, {30'b0, low}, 14'b0));
        end
        check_bit("dcache_req.valid", !ale, dcache_req.valid);
        capture();
        check_bit("ex_mem.is_ale", ale, ex_mem.is_ale);
        check_bit("ex_mem.is_exception", ale, ex_mem.is_exception);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Directed tests
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic test_reset();
        rst = 1'b1;
        repeat (10) @(posedge clk);
        #1;
        check_bit("ex_mem.inst_valid", 1'b0, ex_mem.inst_valid);
        check_bit("ex_mem.reg_write_en", 1'b0, ex_mem.reg_write_en);
        check_bit("ex_mem.csr_write_en", 1'b0, ex_mem.csr_write_en);
        check_bit("dcache_req.valid", 1'b0, dcache_req.valid);
        check_bit("pause", 1'b0, pause);
        rst = 1'b0;
    endtask

    task automatic test_alu();
        aluop_e      ops [14];
        logic [31:0] a;
        logic [31:0] b;
        ops = '{ALU_OR, ALU_NOR, ALU_AND, ALU_XOR, ALU_SLLW, ALU_SRLW, ALU_SRAW,
                ALU_ADDW, ALU_SUBW, ALU_SLT, ALU_SLTU, ALU_MULW, ALU_MULHW, ALU_MULHWU};
        for (int i = 0; i < 14; i++) begin
            for (int k = 0; k < 3; k++) begin
                a = $random(seed);
                b = $random(seed);
                if (k == 0) begin
                    a[31] = 1'b1;                       // Negative operand for sign fill
                end
                present(make_op(ops[i], a, b, 14'b0));
                capture();
                check_word("ex_mem.reg_write_data", alu_model(ops[i], a, b),
                           ex_mem.reg_write_data);
            end
        end
    endtask

    task automatic test_mem();
        aluop_e      st_ops [3];
        aluop_e      ld_ops [5];
        logic [31:0] rnd;
        logic [31:0] base;
        logic [31:0] data;
        logic [11:0] imm;
        st_ops = '{ALU_STB, ALU_STH, ALU_STW};
        ld_ops = '{ALU_LDB, ALU_LDBU, ALU_LDH, ALU_LDHU, ALU_LDW};
        for (int i = 0; i < 3; i++) begin
            for (int k = 0; k < 4; k++) begin
                rnd  = $random(seed);
                base = {rnd[31:2], 2'b00};
                data = $random(seed);
                imm  = {rnd[11:2], 2'b00};
                imm[1:0] = (i == 0) ? k[1:0] : (i == 1) ? {k[0], 1'b0} : 2'b00;
                present(make_op(st_ops[i], base, data, {2'b00, imm}));
                check_req("dcache_req", store_model(st_ops[i], base + {{20{imm[11]}}, imm}, data),
                          dcache_req);
                capture();
                check_word("ex_mem.st_en", 32'b1 << i, {24'b0, ex_mem.st_en});
            end
        end
        for (int i = 0; i < 5; i++) begin
            rnd  = $random(seed);
            base = {rnd[31:2], 2'b00};
            present(make_op(ld_ops[i], base, 32'h40, 14'b0));
            check_bit("dcache_req.valid", 1'b1, dcache_req.valid);
            check_bit("dcache_req.op", 1'b0, dcache_req.op);
            check_word("dcache_req.addr", base + 32'h40, dcache_req.addr);
            capture();
            check_word("ex_mem.ld_en", 32'b1 << i, {24'b0, ex_mem.ld_en});
            check_word("ex_mem.reg_write_data", 32'b0, ex_mem.reg_write_data);
            check_bit("ex_mem.reg_write_en", 1'b1, ex_mem.reg_write_en);
            check_word("ex_mem.reg_write_addr", 32'd7, {27'b0, ex_mem.reg_write_addr});
            check_word("ex_mem.pc", TEST_PC, ex_mem.pc);
            check_word("ex_mem.aluop", {24'b0, ld_ops[i]}, {24'b0, ex_mem.aluop});
        end
    endtask

    task automatic test_misalign();
        aluop_e       ops [4];
        dispatch_ex_t d;
        ops = '{ALU_LDW, ALU_LDH, ALU_STH, ALU_STW};
        for (int i = 0; i < 4; i++) begin
            for (int k = 0; k < 4; k++) begin
                align_case(ops[i], k[1:0]);
            end
        end

        // Aligned load carrying an earlier exception
        d = make_op(ALU_LDW, 32'h0000_1000, 32'h0, 14'b0);
        d.in_exception = 1'b1;
        present(d);
        check_bit("dcache_req.valid", 1'b0, dcache_req.valid);
        capture();
        check_bit("ex_mem.is_ale", 1'b0, ex_mem.is_ale);
        check_bit("ex_mem.is_exception", 1'b1, ex_mem.is_exception);
    endtask

    task automatic test_llsc();
        logic [31:0] rnd;
        logic [31:0] base;
        logic [31:0] data;
        logic [13:0] si14;
        rnd  = $random(seed);
        base = {rnd[31:2], 2'b00};
        data = $random(seed);
        si14 = rnd[15:2];
        present(make_op(ALU_LLW, base, 32'b0, 14'b0));
        capture();
        check_bit("ex_mem.csr_write_en", 1'b1, ex_mem.csr_write_en);
        check_word("ex_mem.csr_addr", {18'b0, CSR_LLBCTL}, {18'b0, ex_mem.csr_addr});
        check_word("ex_mem.csr_write_data", 32'd1, ex_mem.csr_write_data);
        check_word("ex_mem.ld_en", 32'h20, {24'b0, ex_mem.ld_en});
        check_bit("ex_mem.is_llw_scw", 1'b1, ex_mem.is_llw_scw);

        // MEM forward sets the bit that the register file still has clear
        llbit   = 1'b0;
        mem_fwd = '{write_en: 1'b1, addr: CSR_LLBCTL, data: 32'd1};
        present(make_op(ALU_SCW, base, data, si14));
        check_req("dcache_req",
                  store_model(ALU_SCW, base + {{16{si14[13]}}, si14, 2'b00}, data), dcache_req);
        capture();
        check_word("ex_mem.reg_write_data", 32'd1, ex_mem.reg_write_data);
        check_bit("ex_mem.csr_write_en", 1'b1, ex_mem.csr_write_en);
        check_word("ex_mem.csr_write_data", 32'd0, ex_mem.csr_write_data);
        check_word("ex_mem.st_en", 32'h8, {24'b0, ex_mem.st_en});
        check_bit("ex_mem.is_llw_scw", 1'b1, ex_mem.is_llw_scw);

        llbit   = 1'b1;
        mem_fwd = '{write_en: 1'b1, addr: CSR_LLBCTL, data: 32'd0};
        wb_fwd  = '{write_en: 1'b1, addr: CSR_LLBCTL, data: 32'd1};
        present(make_op(ALU_SCW, base, data, si14));
        check_bit("dcache_req.valid", 1'b0, dcache_req.valid);
        capture();
        check_word("ex_mem.reg_write_data", 32'd0, ex_mem.reg_write_data);
        check_bit("ex_mem.csr_write_en", 1'b0, ex_mem.csr_write_en);
        check_word("ex_mem.st_en", 32'h0, {24'b0, ex_mem.st_en});
        check_bit("ex_mem.is_llw_scw", 1'b1, ex_mem.is_llw_scw);
        llbit   = 1'b0;
        mem_fwd = '0;
        wb_fwd  = '0;
    endtask

    task automatic test_stall();
        logic [31:0] rnd;
        logic [31:0] base;
        rnd  = $random(seed);
        base = {rnd[31:2], 2'b00};
        dcache_addr_ok = 1'b0;
        present(make_op(ALU_LDW, base, 32'h8, 14'b0));
        check_bit("pause", 1'b1, pause);
        repeat (3) begin
            @(posedge clk);
            #1;
            check_bit("pause", 1'b1, pause);
            check_bit("ex_mem.inst_valid", 1'b0, ex_mem.inst_valid);
            check_bit("ex_mem.reg_write_en", 1'b0, ex_mem.reg_write_en);
        end
        dcache_addr_ok = 1'b1;
        #10;
        check_bit("pause", 1'b0, pause);
        capture();
        check_bit("ex_mem.inst_valid", 1'b1, ex_mem.inst_valid);
        check_word("ex_mem.mem_addr", base + 32'h8, ex_mem.mem_addr);
    endtask

    initial begin
        rst            = 1'b1;
        dispatch_ex    = '0;
        llbit          = 1'b0;
        mem_fwd        = '0;
        wb_fwd         = '0;
        dcache_addr_ok = 1'b1;
        test_reset();
        test_alu();
        test_mem();
        test_misalign();
        test_llsc();
        test_stall();
        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* verification/ex_stage_assertions.sv */
`timescale 1ns/1ps

module ex_stage_assertions
    import ex_pkg::*;
(
    input logic        clk,
    input logic        rst,
    input dcache_req_t dcache_req,
    input logic        pause,
    input ex_mem_t     ex_mem
);

    // Stall only while a request waits on the cache
    pause_needs_request: assert property (@(posedge clk) pause |-> dcache_req.valid)
        else $error("pause is high with no cache request");

    write_has_strobe: assert property (@(posedge clk)
        (dcache_req.valid && dcache_req.op) |-> (dcache_req.wstrb != 4'b0000))
        else $error("write request with an empty byte strobe");

    reset_clears_valid: assert property (@(posedge clk) rst |=> !ex_mem.inst_valid)
        else $error("ex_mem.inst_valid is set after a reset edge");

endmodule

bind ex_stage ex_stage_assertions u_ex_stage_assertions (
    .clk        (clk),
    .rst        (rst),
    .dcache_req (dcache_req),
    .pause      (pause),
    .ex_mem     (ex_mem)
);

/* verilog/ex_stage.sv */
`timescale 1ns/1ps

module ex_stage
    import ex_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  dispatch_ex_t dispatch_ex,
    input  logic         llbit,
    input  csr_fwd_t     mem_fwd,
    input  csr_fwd_t     wb_fwd,
    input  logic         dcache_addr_ok,
    output dcache_req_t  dcache_req,
    output logic         pause,
    output ex_mem_t      ex_mem
);

    logic [31:0] alu_result;
    mem_info_t   mem_info;
    logic        sc_success;
    csr_fwd_t    ll_csr_write;

    llbit_unit u_llbit_unit (
        .aluop         (dispatch_ex.aluop),
        .llbit         (llbit),
        .mem_fwd       (mem_fwd),
        .wb_fwd        (wb_fwd),
        .llbit_current (),                  // Only needed inside the unit
        .sc_success    (sc_success),
        .ll_csr_write  (ll_csr_write)
    );

    alu u_alu (
        .dispatch_ex (dispatch_ex),
        .alu_result  (alu_result)
    );

    mem_access_unit u_mem_access_unit (
        .dispatch_ex    (dispatch_ex),
        .sc_success     (sc_success),
        .dcache_addr_ok (dcache_addr_ok),
        .dcache_req     (dcache_req),
        .mem_info       (mem_info),
        .pause          (pause)
    );

    ex_result_latch u_ex_result_latch (
        .clk          (clk),
        .rst          (rst),
        .dispatch_ex  (dispatch_ex),
        .alu_result   (alu_result),
        .mem_info     (mem_info),
        .ll_csr_write (ll_csr_write),
        .sc_success   (sc_success),
        .pause        (pause),
        .ex_mem       (ex_mem)
    );

endmodule

/* verilog/ex_result_latch.sv */
`timescale 1ns/1ps

module ex_result_latch
    import ex_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  dispatch_ex_t dispatch_ex,
    input  logic [31:0]  alu_result,
    input  mem_info_t    mem_info,
    input  csr_fwd_t     ll_csr_write,
    input  logic         sc_success,
    input  logic         pause,
    output ex_mem_t      ex_mem
);

    ex_mem_t ex_next;

    always_comb begin
        ex_next.pc             = dispatch_ex.pc;
        ex_next.inst_valid     = dispatch_ex.inst_valid;
        ex_next.aluop          = dispatch_ex.aluop;
        ex_next.reg_write_en   = dispatch_ex.reg_write_en;
        ex_next.reg_write_addr = dispatch_ex.reg_write_addr;

        // The ALU already gives 0 for loads and stores
        if (dispatch_ex.aluop == ALU_SCW) begin
            ex_next.reg_write_data = {31'b0, sc_success};
        end else begin
            ex_next.reg_write_data = alu_result;
        end

        ex_next.mem_addr       = mem_info.mem_addr;
        ex_next.is_ale         = mem_info.is_ale;
        ex_next.is_exception   = dispatch_ex.in_exception || mem_info.is_ale;
        ex_next.ld_en          = mem_info.ld_en;
        ex_next.st_en          = mem_info.st_en;
        ex_next.csr_write_en   = ll_csr_write.write_en;
        ex_next.csr_addr       = ll_csr_write.addr;
        ex_next.csr_write_data = ll_csr_write.data;
        ex_next.is_llw_scw     = (dispatch_ex.aluop == ALU_LLW) ||
                                 (dispatch_ex.aluop == ALU_SCW);
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // EX/MEM register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        ex_mem <= ex_next;
        if (rst || pause) begin
            ex_mem.inst_valid   <= 1'b0;    // Bubble
            ex_mem.reg_write_en <= 1'b0;
            ex_mem.csr_write_en <= 1'b0;
        end
    end

endmodule

/* verilog/llbit_unit.sv */
`timescale 1ns/1ps

module llbit_unit
    import ex_pkg::*;
(
    input  aluop_e   aluop,
    input  logic     llbit,
    input  csr_fwd_t mem_fwd,
    input  csr_fwd_t wb_fwd,
    output logic     llbit_current,
    output logic     sc_success,
    output csr_fwd_t ll_csr_write
);

    logic mem_hit;
    logic wb_hit;

    assign mem_hit = mem_fwd.write_en && (mem_fwd.addr == CSR_LLBCTL);
    assign wb_hit  = wb_fwd.write_en && (wb_fwd.addr == CSR_LLBCTL);

    // Youngest writer wins
    always_comb begin
        if (mem_hit) begin
            llbit_current = mem_fwd.data[0];
        end else if (wb_hit) begin
            llbit_current = wb_fwd.data[0];
        end else begin
            llbit_current = llbit;
        end
    end

    assign sc_success = (aluop == ALU_SCW) && llbit_current;

    // LL.W sets the bit, a successful SC.W clears it
    assign ll_csr_write.write_en = (aluop == ALU_LLW) || sc_success;
    assign ll_csr_write.addr     = CSR_LLBCTL;
    assign ll_csr_write.data     = {31'b0, aluop == ALU_LLW};

endmodule

/* verilog/mem_access_unit.sv */
`timescale 1ns/1ps

module mem_access_unit
    import ex_pkg::*;
(
    input  dispatch_ex_t dispatch_ex,
    input  logic         sc_success,
    input  logic         dcache_addr_ok,
    output dcache_req_t  dcache_req,
    output mem_info_t    mem_info,
    output logic         pause
);

    logic [11:0] si12;
    logic [13:0] si14;
    logic [31:0] store_offset;
    logic [31:0] sc_offset;
    logic [31:0] mem_addr;

    logic        is_mem;
    logic        is_ale;
    logic        sc_fail;

    assign si12 = dispatch_ex.inst.fmt_2ri12.si12;
    assign si14 = dispatch_ex.inst.fmt_2ri14.si14;

    assign store_offset = {{20{si12[11]}}, si12};
    assign sc_offset    = {{16{si14[13]}}, si14, 2'b00};

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Address generation
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        case (dispatch_ex.aluop)
            ALU_LDB, ALU_LDBU, ALU_LDH, ALU_LDHU, ALU_LDW, ALU_LLW: begin
                mem_addr = dispatch_ex.reg1 + dispatch_ex.reg2;
            end
            ALU_STB, ALU_STH, ALU_STW: begin
                mem_addr = dispatch_ex.reg1 + store_offset;
            end
            ALU_SCW: begin
                mem_addr = dispatch_ex.reg1 + sc_offset;
            end
            default: begin
                mem_addr = 32'b0;
            end
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Alignment and store lanes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        is_mem           = 1'b1;
        is_ale           = 1'b0;
        dcache_req.op    = 1'b0;
        dcache_req.wdata = dispatch_ex.reg2;
        dcache_req.wstrb = 4'b1111;
        case (dispatch_ex.aluop)
            ALU_LDB, ALU_LDBU: begin
                is_ale = 1'b0;                                  // Any byte address
            end
            ALU_LDH, ALU_LDHU: begin
                is_ale = mem_addr[0];
            end
            ALU_LDW, ALU_LLW: begin
                is_ale = |mem_addr[1:0];
            end
            ALU_STB: begin
                dcache_req.op    = 1'b1;
                dcache_req.wdata = {4{dispatch_ex.reg2[7:0]}};
                dcache_req.wstrb = 4'b0001 << mem_addr[1:0];
            end
            ALU_STH: begin
                is_ale           = mem_addr[0];
                dcache_req.op    = 1'b1;
                dcache_req.wdata = {2{dispatch_ex.reg2[15:0]}};
                dcache_req.wstrb = mem_addr[1] ? 4'b1100 : 4'b0011;
            end
            ALU_STW, ALU_SCW: begin
                is_ale        = |mem_addr[1:0];
                dcache_req.op = 1'b1;
            end
            default: begin
                is_mem           = 1'b0;
                dcache_req.wdata = 32'b0;
            end
        endcase
    end

    assign sc_fail = (dispatch_ex.aluop == ALU_SCW) && !sc_success;

    assign dcache_req.valid = is_mem && !is_ale && !dispatch_ex.in_exception && !sc_fail;
    assign dcache_req.addr  = mem_addr;

    assign pause = dcache_req.valid && !dcache_addr_ok;    // Waiting on the cache

    assign mem_info.mem_addr = mem_addr;
    assign mem_info.is_ale   = is_ale;
    assign mem_info.ld_en    = {2'b0,
                                dispatch_ex.aluop == ALU_LLW,
                                dispatch_ex.aluop == ALU_LDW,
                                dispatch_ex.aluop == ALU_LDHU,
                                dispatch_ex.aluop == ALU_LDH,
                                dispatch_ex.aluop == ALU_LDBU,
                                dispatch_ex.aluop == ALU_LDB};
    assign mem_info.st_en    = {4'b0,
                                (dispatch_ex.aluop == ALU_SCW) && sc_success,
                                dispatch_ex.aluop == ALU_STW,
                                dispatch_ex.aluop == ALU_STH,
                                dispatch_ex.aluop == ALU_STB};

endmodule

/* verilog/alu.sv */
`timescale 1ns/1ps

module alu
    import ex_pkg::*;
(
    input  dispatch_ex_t dispatch_ex,
    output logic [31:0]  alu_result
);

    logic [31:0] reg1;
    logic [31:0] reg2;
    logic [4:0]  shamt;

    logic [31:0] logic_res;
    logic [31:0] shift_res;

    logic        sub_en;
    logic [31:0] adder_b;
    logic [31:0] sum;
    logic        lt_signed;
    logic        lt_unsigned;

    logic        mul_signed;
    logic [32:0] mul_a;
    logic [32:0] mul_b;
    logic [65:0] product;

    assign reg1  = dispatch_ex.reg1;
    assign reg2  = dispatch_ex.reg2;
    assign shamt = reg2[4:0];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Logic and shift
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        case (dispatch_ex.aluop)
            ALU_OR:  logic_res = reg1 | reg2;
            ALU_NOR: logic_res = ~(reg1 | reg2);
            ALU_AND: logic_res = reg1 & reg2;
            default: logic_res = reg1 ^ reg2;
        endcase
    end

    always_comb begin
        case (dispatch_ex.aluop)
            ALU_SLLW: shift_res = reg1 << shamt;
            ALU_SRLW: shift_res = reg1 >> shamt;
            default:  shift_res = $unsigned($signed(reg1) >>> shamt);   // Sign fill
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Adder and compare
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign sub_en  = (dispatch_ex.aluop == ALU_SUBW) || (dispatch_ex.aluop == ALU_SLT);
    assign adder_b = sub_en ? ~reg2 : reg2;
    assign sum     = reg1 + adder_b + {31'b0, sub_en};

    // Sign of the difference decides when the operand signs agree
    assign lt_signed   = (reg1[31] & ~reg2[31]) | (~(reg1[31] ^ reg2[31]) & sum[31]);
    assign lt_unsigned = reg1 < reg2;

    // One 33x33 multiplier covers both signed and unsigned forms
    assign mul_signed = dispatch_ex.aluop != ALU_MULHWU;
    assign mul_a      = {mul_signed & reg1[31], reg1};
    assign mul_b      = {mul_signed & reg2[31], reg2};
    assign product    = $signed(mul_a) * $signed(mul_b);

    always_comb begin
        case (dispatch_ex.aluop)
            ALU_OR, ALU_NOR, ALU_AND, ALU_XOR: alu_result = logic_res;
            ALU_SLLW, ALU_SRLW, ALU_SRAW:      alu_result = shift_res;
            ALU_ADDW, ALU_SUBW:                alu_result = sum;
            ALU_SLT:                           alu_result = {31'b0, lt_signed};
            ALU_SLTU:                          alu_result = {31'b0, lt_unsigned};
            ALU_MULW:                          alu_result = product[31:0];
            ALU_MULHW, ALU_MULHWU:             alu_result = product[63:32];
            default:                           alu_result = 32'b0;
        endcase
    end

endmodule

/* verilog/ex_pkg.sv */
package ex_pkg;

    localparam logic [13:0] CSR_LLBCTL = 14'h060;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Execute opcodes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [7:0] {
        ALU_NOP    = 8'h00,
        ALU_OR     = 8'h01,
        ALU_NOR    = 8'h02,
        ALU_AND    = 8'h03,
        ALU_XOR    = 8'h04,
        ALU_SLLW   = 8'h10,
        ALU_SRLW   = 8'h11,
        ALU_SRAW   = 8'h12,
        ALU_ADDW   = 8'h20,
        ALU_SUBW   = 8'h21,
        ALU_SLT    = 8'h22,
        ALU_SLTU   = 8'h23,
        ALU_MULW   = 8'h24,
        ALU_MULHW  = 8'h25,
        ALU_MULHWU = 8'h26,
        ALU_LDB    = 8'h40,
        ALU_LDBU   = 8'h41,
        ALU_LDH    = 8'h42,
        ALU_LDHU   = 8'h43,
        ALU_LDW    = 8'h44,
        ALU_LLW    = 8'h45,
        ALU_STB    = 8'h50,
        ALU_STH    = 8'h51,
        ALU_STW    = 8'h52,
        ALU_SCW    = 8'h53
    } aluop_e;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Instruction word formats
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        logic [9:0]  opcode;
        logic [11:0] si12;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } fmt_2ri12_t;

    typedef struct packed {
        logic [7:0]  opcode;
        logic [13:0] si14;                  // Word offset for LL/SC
        logic [4:0]  rj;
        logic [4:0]  rd;
    } fmt_2ri14_t;

    typedef union packed {
        fmt_2ri12_t fmt_2ri12;
        fmt_2ri14_t fmt_2ri14;
    } inst_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Pipeline bundles
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        logic [31:0] pc;
        inst_t       inst;
        logic        inst_valid;
        aluop_e      aluop;
        logic [31:0] reg1;
        logic [31:0] reg2;
        logic        reg_write_en;
        logic [4:0]  reg_write_addr;
        logic        in_exception;          // Raised by an earlier stage
    } dispatch_ex_t;

    typedef struct packed {
        logic        write_en;
        logic [13:0] addr;
        logic [31:0] data;
    } csr_fwd_t;

    typedef struct packed {
        logic        valid;
        logic        op;                    // 1 = write
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
    } dcache_req_t;

    typedef struct packed {
        logic [31:0] mem_addr;
        logic        is_ale;
        logic [7:0]  ld_en;
        logic [7:0]  st_en;
    } mem_info_t;

    typedef struct packed {
        logic [31:0] pc;
        logic        inst_valid;
        aluop_e      aluop;
        logic        reg_write_en;
        logic [4:0]  reg_write_addr;
        logic [31:0] reg_write_data;
        logic [31:0] mem_addr;
        logic        is_exception;
        logic        is_ale;
        logic [7:0]  ld_en;
        logic [7:0]  st_en;
        logic        csr_write_en;
        logic [13:0] csr_addr;
        logic [31:0] csr_write_data;
        logic        is_llw_scw;
    } ex_mem_t;

endpackage
